// File: hw/capture_pkg.sv
package capture_pkg;

    // active input geometry
    localparam int IN_COLS = 640;
    localparam int IN_ROWS = 480;

    // keep ratios
    localparam int H_DECIM    = 4;  // one pixel in four
    localparam int V_DECIM    = 4;  // one line in four
    localparam int FRAME_KEEP = 3;  // one frame in three

    // stored image
    localparam int OUT_COLS = IN_COLS / H_DECIM;
    localparam int OUT_ROWS = IN_ROWS / V_DECIM;

    localparam int ADDR_W = 15;  // frame buffer word address
    localparam int PIX_W  = 8;   // luma sample

    // memory side flow control
    localparam int FIFO_DEPTH = 16;
    localparam int CREDIT_MAX = 8;  // credits held after reset

    typedef enum logic [1:0] {
        FS_WAIT,     // no vsync seen since reset
        FS_CAPTURE,  // current frame is written out
        FS_SKIP      // current frame is discarded
    } frame_state_t;

endpackage

// File: hw/credit_tx.sv
module credit_tx import capture_pkg::*; (
    input  logic              pclk,
    input  logic              i_reset,
    input  logic              i_luma_valid,
    input  logic [PIX_W-1:0]  i_luma,
    input  logic [ADDR_W-1:0] i_luma_addr,
    input  logic              i_credit_return,
    output logic              o_wr_valid,
    output logic [ADDR_W-1:0] o_wr_addr,
    output logic [PIX_W-1:0]  o_wr_data,
    output logic              o_overflow
);

    localparam int WORD_W = ADDR_W + PIX_W;
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W  = $clog2(CREDIT_MAX + 1);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];  // {addr, luma}
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;             // words held
    logic [CRD_W-1:0]  credits;           // beats the sink can still take
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;
    logic              drop;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = i_luma_valid && !full;
    assign drop  = i_luma_valid && full;  // no room, pixel is lost
    assign pop   = !empty && (credits != '0);

    // head word goes out as soon as a credit is available
    assign o_wr_valid             = pop;
    assign {o_wr_addr, o_wr_data} = mem[rd_ptr];

    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr] <= {i_luma_addr, i_luma};
        end
    end

    always_ff @(posedge pclk) begin
        if (i_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CRD_W'(CREDIT_MAX);
            o_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case ({i_credit_return, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;  // return and spend cancel
            endcase

            if (drop) begin
                o_overflow <= 1'b1;  // sticky until reset
            end
        end
    end

    // the sink never hands back more credits than it was sent beats
    a_credit_limit: assert property (
        @(posedge pclk) disable iff (i_reset)
        credits <= CRD_W'(CREDIT_MAX)
    );

    // out of credits and none coming back means nothing is sent next cycle
    a_no_send_without_credit: assert property (
        @(posedge pclk) disable iff (i_reset)
        (credits == '0 && !i_credit_return) |=> !o_wr_valid
    );

endmodule

// File: hw/frame_sync.sv
module frame_sync import capture_pkg::*; (
    input  logic       pclk,
    input  logic       i_reset,
    input  logic       i_vsync_n,
    input  logic       i_vde,
    output logic       o_line_keep,
    output logic [6:0] o_row,
    output logic       o_frame_start
);

    localparam int FRAME_W = $clog2(FRAME_KEEP);
    localparam int LINE_W  = $clog2(IN_ROWS + 1);

    frame_state_t       state;
    logic               vsync_q;    // previous vsync sample
    logic               vde_q;      // previous vde sample
    logic [FRAME_W-1:0] frame_cnt;  // index of the next frame, mod FRAME_KEEP
    logic [LINE_W-1:0]  line_cnt;   // active line index within the frame
    logic               vsync_fall;
    logic               vde_fall;

    assign vsync_fall = vsync_q & ~i_vsync_n;  // high sample then low sample
    assign vde_fall   = vde_q & ~i_vde;        // end of an active line

    always_ff @(posedge pclk) begin
        if (i_reset) begin
            vsync_q       <= 1'b0;  // a real high sample is needed first
            vde_q         <= 1'b0;
            state         <= FS_WAIT;
            frame_cnt     <= '0;
            line_cnt      <= '0;
            o_frame_start <= 1'b0;
        end else begin
            vsync_q <= i_vsync_n;
            vde_q   <= i_vde;

            if (vsync_fall) begin
                state     <= (frame_cnt == '0) ? FS_CAPTURE : FS_SKIP;
                frame_cnt <= (frame_cnt == FRAME_W'(FRAME_KEEP - 1)) ? '0 : frame_cnt + 1'b1;
                line_cnt  <= '0;
            end else if (vde_fall && line_cnt != LINE_W'(IN_ROWS)) begin
                line_cnt <= line_cnt + 1'b1;  // saturates past the last row
            end

            o_frame_start <= vsync_fall && (frame_cnt == '0);
        end
    end

    // decision for the line that is about to start
    assign o_line_keep = (state == FS_CAPTURE)
                      && (line_cnt < LINE_W'(IN_ROWS))
                      && ((line_cnt % V_DECIM) == 0);
    assign o_row = 7'(line_cnt / V_DECIM);

    // frame start is a single pulse per captured frame
    a_frame_start_pulse: assert property (
        @(posedge pclk) disable iff (i_reset)
        o_frame_start |=> !o_frame_start
    );

endmodule

// File: hw/luma_convert.sv
module luma_convert import capture_pkg::*; (
    input  logic              pclk,
    input  logic              i_reset,
    input  logic              i_pix_valid,
    input  logic [23:0]       i_pix_rgb,
    input  logic [ADDR_W-1:0] i_pix_addr,
    output logic              o_luma_valid,
    output logic [PIX_W-1:0]  o_luma,
    output logic [ADDR_W-1:0] o_luma_addr
);

    logic [15:0] r;
    logic [15:0] g;
    logic [15:0] b;
    logic [15:0] sum;

    assign r = 16'(i_pix_rgb[23:16]);
    assign g = 16'(i_pix_rgb[15:8]);
    assign b = 16'(i_pix_rgb[7:0]);

    // 77 r + 150 g + 29 b, max 255 * 256 so 16 bits suffice
    assign sum = (r << 6) + (r << 3) + (r << 2) + r
               + (g << 7) + (g << 4) + (g << 2) + (g << 1)
               + (b << 4) + (b << 3) + (b << 2) + b;

    always_ff @(posedge pclk) begin
        if (i_reset) begin
            o_luma_valid <= 1'b0;
        end else begin
            o_luma_valid <= i_pix_valid;
        end
    end

    always_ff @(posedge pclk) begin
        o_luma      <= sum[15:8];  // divide by 256
        o_luma_addr <= i_pix_addr;
    end

endmodule

// File: hw/pixel_decimator.sv
module pixel_decimator import capture_pkg::*; (
    input  logic              pclk,
    input  logic              i_reset,
    input  logic              i_vde,
    input  logic [23:0]       i_rgb,
    input  logic              i_line_keep,
    input  logic [6:0]        i_row,
    output logic              o_pix_valid,
    output logic [23:0]       o_pix_rgb,
    output logic [ADDR_W-1:0] o_pix_addr
);

    localparam int PH_W  = $clog2(H_DECIM);
    localparam int COL_W = $clog2(OUT_COLS);

    logic [PH_W-1:0]   phase;     // position within the current group of pixels
    logic [COL_W-1:0]  col;       // output column of the next kept pixel
    logic              take;
    logic [ADDR_W-1:0] pix_addr;

    // first pixel of each group on a kept line
    assign take = i_vde
               && i_line_keep
               && (phase == '0)
               && (col < COL_W'(IN_COLS / H_DECIM));

    assign pix_addr = ADDR_W'(i_row * OUT_COLS) + ADDR_W'(col);

    always_ff @(posedge pclk) begin
        if (i_reset) begin
            phase       <= '0;
            col         <= '0;
            o_pix_valid <= 1'b0;
        end else begin
            if (i_vde) begin
                phase <= (phase == PH_W'(H_DECIM - 1)) ? '0 : phase + 1'b1;
            end else begin
                phase <= '0;  // restart on every line
            end

            if (!i_vde) begin
                col <= '0;
            end else if (take) begin
                col <= col + 1'b1;
            end

            o_pix_valid <= take;
        end
    end

    // pixel and its address, held until the next kept pixel
    always_ff @(posedge pclk) begin
        if (take) begin
            o_pix_rgb  <= i_rgb;
            o_pix_addr <= pix_addr;
        end
    end

endmodule

// File: hw/video_capture_top.sv
module video_capture_top import capture_pkg::*; (
    input  logic              pclk,
    input  logic              i_reset,
    input  logic              i_hsync_n,  // line timing is taken from vde edges
    input  logic              i_vsync_n,
    input  logic              i_vde,
    input  logic [23:0]       i_rgb,
    input  logic              i_credit_return,
    output logic              o_wr_valid,
    output logic [ADDR_W-1:0] o_wr_addr,
    output logic [PIX_W-1:0]  o_wr_data,
    output logic              o_frame_start,
    output logic              o_overflow
);

    logic              line_keep;
    logic [6:0]        row;
    logic              pix_valid;
    logic [23:0]       pix_rgb;
    logic [ADDR_W-1:0] pix_addr;
    logic              luma_valid;
    logic [PIX_W-1:0]  luma;
    logic [ADDR_W-1:0] luma_addr;

    frame_sync u_frame_sync (
        .pclk          (pclk),
        .i_reset       (i_reset),
        .i_vsync_n     (i_vsync_n),
        .i_vde         (i_vde),
        .o_line_keep   (line_keep),
        .o_row         (row),
        .o_frame_start (o_frame_start)
    );

    pixel_decimator u_pixel_decimator (
        .pclk        (pclk),
        .i_reset     (i_reset),
        .i_vde       (i_vde),
        .i_rgb       (i_rgb),
        .i_line_keep (line_keep),
        .i_row       (row),
        .o_pix_valid (pix_valid),
        .o_pix_rgb   (pix_rgb),
        .o_pix_addr  (pix_addr)
    );

    luma_convert u_luma_convert (
        .pclk         (pclk),
        .i_reset      (i_reset),
        .i_pix_valid  (pix_valid),
        .i_pix_rgb    (pix_rgb),
        .i_pix_addr   (pix_addr),
        .o_luma_valid (luma_valid),
        .o_luma       (luma),
        .o_luma_addr  (luma_addr)
    );

    credit_tx u_credit_tx (
        .pclk            (pclk),
        .i_reset         (i_reset),
        .i_luma_valid    (luma_valid),
        .i_luma          (luma),
        .i_luma_addr     (luma_addr),
        .i_credit_return (i_credit_return),
        .o_wr_valid      (o_wr_valid),
        .o_wr_addr       (o_wr_addr),
        .o_wr_data       (o_wr_data),
        .o_overflow      (o_overflow)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the capture testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_video_capture -f sim.f -o tb_video_capture_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_video_capture_sim > sim.log 2>&1
run_status=$?
cat sim.log

# the log decides pass or fail
if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0

// File: sim.f
+incdir+testbench
hw/capture_pkg.sv
hw/frame_sync.sv
hw/pixel_decimator.sv
hw/luma_convert.sv
hw/credit_tx.sv
hw/video_capture_top.sv
testbench/tb_video_capture.sv

// File: testbench/tb_capture_model.svh
`ifndef TB_CAPTURE_MODEL_SVH
`define TB_CAPTURE_MODEL_SVH

logic [ADDR_W-1:0] exp_addr_q[$];  // expected writes, oldest first
logic [PIX_W-1:0]  exp_data_q[$];
int                model_budget;   // words the memory side will still take this frame

// xorshift32 with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic int expected_luma(input logic [23:0] rgb);
    int r;
    int g;
    int b;
    r = int'(rgb[23:16]);
    g = int'(rgb[15:8]);
    b = int'(rgb[7:0]);
    return (77 * r + 150 * g + 29 * b) / 256;  // weights sum to 256
endfunction

// pixel j of active line k in frame n, as seen by the DUT
task automatic model_pixel(input int n, input int k, input int j, input logic [23:0] rgb);
    int addr;
    if (n % FRAME_KEEP != 0 || k % V_DECIM != 0 || j % H_DECIM != 0) begin
        return;  // frame, line or pixel not kept
    end
    if (model_budget == 0) begin
        return;  // would be stuck in the FIFO or dropped
    end
    model_budget--;
    addr = (k / V_DECIM) * OUT_COLS + j / H_DECIM;
    exp_addr_q.push_back(ADDR_W'(addr));
    exp_data_q.push_back(PIX_W'(expected_luma(rgb)));
endtask

`endif

// File: testbench/tb_video_capture.sv
module tb_video_capture import capture_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HB_MIN     = 16;  // horizontal blanking 16..47 cycles
    localparam int HB_SPAN    = 32;
    localparam int VB_MIN     = 5;   // vertical blanking 5..12 lines
    localparam int VB_SPAN    = 8;
    localparam int NUM_FRAMES = 7;
    localparam int HOLD_FRAME = 6;   // sink keeps every credit from here on
    localparam int MAX_FRAME_CYCLES = (IN_ROWS + VB_MIN + VB_SPAN - 1)
                                    * (IN_COLS + HB_MIN + HB_SPAN - 1);
    localparam logic [31:0] SEED = 32'he2ee473c;

    logic              pclk;
    logic              i_reset;
    logic              i_hsync_n;
    logic              i_vsync_n;
    logic              i_vde;
    logic [23:0]       i_rgb;
    logic              i_credit_return;
    logic              o_wr_valid;
    logic [ADDR_W-1:0] o_wr_addr;
    logic [PIX_W-1:0]  o_wr_data;
    logic              o_frame_start;
    logic              o_overflow;

    logic [31:0] pix_rng;
    logic [31:0] sink_rng;
    int          cur_frame;
    int          cycle;
    int          beats_total;
    int          returns_total;
    int          beats_in_frame[NUM_FRAMES];
    int          starts_in_frame[NUM_FRAMES];
    int          due_q[$];      // cycle at which each credit goes back
    bit          credit_hold;
    bit          ovf_expected;
    bit          fs_prev;

    `include "tb_capture_model.svh"

    video_capture_top uut (.*);

    initial pclk = 1'b0;
    always #2 pclk = ~pclk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first failing check");
    endtask

    // one clock, outputs looked at on the falling edge, sink drives its credit line
    task automatic next_cycle();
        @(negedge pclk);
        cycle++;
        if (o_frame_start) begin
            assert (!fs_prev) else report_failure("o_frame_start high on two cycles in a row");
            assert (cur_frame % FRAME_KEEP == 0)
                else report_failure("o_frame_start pulsed outside a captured frame");
            starts_in_frame[cur_frame]++;
        end
        fs_prev = o_frame_start;
        if (o_wr_valid) begin
            assert (cur_frame >= 0 && starts_in_frame[cur_frame] == 1)
                else report_failure("write seen before the frame's o_frame_start");
            assert (exp_addr_q.size() > 0) else report_failure("write seen with none expected");
            assert (o_wr_addr == exp_addr_q[0]) else report_failure($sformatf(
                "[ERROR] %0d ns o_wr_addr got %0d expected %0d", $time, o_wr_addr, exp_addr_q[0]));
            assert (o_wr_data == exp_data_q[0]) else report_failure($sformatf(
                "[ERROR] %0d ns o_wr_data got %0d expected %0d", $time, o_wr_data, exp_data_q[0]));
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            beats_in_frame[cur_frame]++;
            beats_total++;
            sink_rng = xorshift32(sink_rng);
            due_q.push_back(cycle + int'(sink_rng % 8));  // 0..7 cycles later
        end
        i_credit_return = 1'b0;
        if (!credit_hold && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            i_credit_return = 1'b1;
            returns_total++;
        end
        assert (beats_total - returns_total <= CREDIT_MAX)
            else report_failure("more beats outstanding than the credit limit");
        if (ovf_expected) begin
            assert (o_overflow) else report_failure("o_overflow dropped before reset");
        end else if (cur_frame < HOLD_FRAME) begin
            assert (!o_overflow) else report_failure("o_overflow set while credits flowed");
        end
    endtask

    // one line time, active or blank, hsync pulse inside the blanking
    task automatic drive_line(input int f, input int k, input bit active, input bit vs_low);
        int hb;
        pix_rng = xorshift32(pix_rng);
        hb = HB_MIN + int'(pix_rng % HB_SPAN);
        for (int j = 0; j < IN_COLS + hb; j++) begin
            next_cycle();
            i_vsync_n = !vs_low;
            i_vde     = active && (j < IN_COLS);
            i_hsync_n = !(j >= IN_COLS + 4 && j < IN_COLS + 12);
            if (active && j < IN_COLS) begin
                pix_rng = xorshift32(pix_rng);
                i_rgb   = pix_rng[23:0];
                model_pixel(f, k, j, i_rgb);
            end
        end
    endtask

    task automatic check_frame(input int f);
        int want_starts;
        int want_beats;
        want_starts = (f % FRAME_KEEP == 0) ? 1 : 0;
        want_beats  = (f == HOLD_FRAME) ? CREDIT_MAX : want_starts * OUT_COLS * OUT_ROWS;
        assert (beats_in_frame[f] == want_beats) else report_failure($sformatf(
            "[ERROR] %0d ns o_wr_valid beats in frame %0d got %0d expected %0d",
            $time, f, beats_in_frame[f], want_beats));
        assert (starts_in_frame[f] == want_starts) else report_failure($sformatf(
            "[ERROR] %0d ns o_frame_start pulses in frame %0d got %0d expected %0d",
            $time, f, starts_in_frame[f], want_starts));
        assert (exp_addr_q.size() == 0) else report_failure("expected writes never appeared");
    endtask

    initial begin
        int vb;
        pix_rng         = SEED;
        sink_rng        = ~SEED;  // own stream for credit delays
        cur_frame       = -1;
        model_budget    = 0;
        i_reset         = 1'b1;
        i_hsync_n       = 1'b1;
        i_vsync_n       = 1'b1;
        i_vde           = 1'b0;
        i_rgb           = '0;
        i_credit_return = 1'b0;
        repeat (10) @(posedge pclk);
        @(negedge pclk);
        i_reset = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            pix_rng = xorshift32(pix_rng);
            vb = VB_MIN + int'(pix_rng % VB_SPAN);
            for (int v = 0; v < vb; v++) begin
                if (v == 1) begin
                    if (f > 0) begin
                        check_frame(f - 1);
                    end
                    cur_frame    = f;
                    credit_hold  = (f == HOLD_FRAME);
                    model_budget = (f == HOLD_FRAME) ? CREDIT_MAX : OUT_COLS * OUT_ROWS;
                end
                drive_line(f, 0, 1'b0, v == 1 || v == 2);  // vsync low for two lines
            end
            for (int k = 0; k < IN_ROWS; k++) begin
                drive_line(f, k, 1'b1, 1'b0);
                if (f == HOLD_FRAME && k == 0) begin
                    assert (o_overflow)
                        else report_failure("o_overflow not set after a kept line without credits");
                    ovf_expected = 1'b1;
                end
            end
        end
        repeat (64) next_cycle();
        check_frame(NUM_FRAMES - 1);
        $display("NO ERRORS");
        $finish;
    end

    // eight of the longest frames
    initial begin
        #(8 * MAX_FRAME_CYCLES * 4);
        report_failure("timeout, the run did not finish within eight frame times");
    end

endmodule
